//--- compile.f
+incdir+tb
common/z80BusPkg.sv
common/z80PadPkg.sv
hw/cycleSequencer.sv
pinControl/pinControl.sv
pinControl/padLatches.sv
hw/busCycleTop.sv
tb/busCycleTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = busCycleTb
FILELIST  = compile.f
LOG       = sim.log
PASSMSG   = Regression passed

.PHONY: simulate clean

# Build, run, then decide on the log contents
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/busCycleModel.svh
// Bus cycle reference model

`ifndef BUS_CYCLE_MODEL_SVH
`define BUS_CYCLE_MODEL_SVH

//------------------------------------------------------------
// T-state order and timing per function
//------------------------------------------------------------
function automatic int stateCount(input busFunc f);
    return (f == memRead || f == memWrite) ? 3 : 4;     // Before any wait repeat
endfunction

function automatic tState stateAt(input busFunc f, input int i);
    case (i)
        0:       return t1;
        1:       return t2;
        2:       return (f == intrAck) ? tw1 : t3;
        default: return (f == intrAck) ? tw2 : t4;
    endcase
endfunction

// T-state where WAIT is looked at
function automatic tState waitState(input busFunc f);
    case (f)
        ioRead, ioWrite: return t3;
        intrAck:         return tw2;
        default:         return t2;                      // Fetch and memory cycles
    endcase
endfunction

// Start cycle to cycleDone
function automatic int latencyOf(input busFunc f, input int repeats);
    return ((f == memRead || f == memWrite) ? 6 : 8) + 2 * repeats;
endfunction

//------------------------------------------------------------
// Strobe table, each row {high half, low half}
//------------------------------------------------------------
// Bit order m1 mreq iorq rd wr rfsh
function automatic logic [11:0] strobeRow(input busFunc f, input tState s);
    case ({f, s})
        {fetch, t1}:     return 12'b100000_110100;
        {fetch, t2}:     return 12'b110100_110100;
        {fetch, t3}:     return 12'b000001_010001;       // Refresh half of M1
        {fetch, t4}:     return 12'b010001_000001;
        {memRead, t1}:   return 12'b000000_010100;
        {memRead, t2}:   return 12'b010100_010100;
        {memRead, t3}:   return 12'b010100_000000;
        {memWrite, t1}:  return 12'b000000_010000;
        {memWrite, t2}:  return 12'b010000_010010;
        {memWrite, t3}:  return 12'b010010_000000;
        {ioRead, t2}:    return 12'b001100_001100;
        {ioRead, t3}:    return 12'b001100_001100;
        {ioRead, t4}:    return 12'b001100_000000;
        {ioWrite, t2}:   return 12'b001010_001010;
        {ioWrite, t3}:   return 12'b001010_001010;
        {ioWrite, t4}:   return 12'b001010_000000;
        {intrAck, t1}:   return 12'b100000_100000;
        {intrAck, t2}:   return 12'b100000_100000;
        {intrAck, tw1}:  return 12'b100001_111001;
        {intrAck, tw2}:  return 12'b111001_101001;
        default:         return 12'b000000_000000;       // Idle and unused states
    endcase
endfunction

function automatic logic [5:0] expPins(input busFunc f, input tState s, input logic low);
    logic [11:0] row;
    row = strobeRow(f, s);
    return low ? row[5:0] : row[11:6];
endfunction

// Writes drive D from the low half of T1 to the end of the cycle
function automatic logic drivesData(input busFunc f, input tState s, input logic low);
    return (f == memWrite || f == ioWrite) && s != tIdle && !(s == t1 && !low);
endfunction

function automatic logic readsBack(input busFunc f);
    return !(f == memWrite || f == ioWrite);
endfunction

//------------------------------------------------------------
// Interrupt priority
//------------------------------------------------------------
function automatic logic [1:0] irqExpect(input logic done, input logic pending, input logic intr);
    return {done && pending, done && !pending && intr};  // NMI first
endfunction

function automatic logic nmiNext(input logic rise, input logic pending, input logic done);
    return rise || (pending && !done);
endfunction

`endif

//--- tb/busCycleTb.sv
// Bus cycle unit testbench

module busCycleTb;

    import z80BusPkg::*;
    import z80PadPkg::*;

    `include "busCycleModel.svh"

    localparam int numReqs   = 300;
    localparam int maxCycles = numReqs * (8 + 2 * 2 + 10) + 100;  // Hold, gap and ready slack

    logic      lastT = 1'b0;
    logic      rstN;
    busReq     req;
    logic      mwait, busrq, intr, nmi;
    pinStrobes pins;
    logic      busack, addrOe, dataOe, cycleDone, ready;
    logic [addrWidth-1:0] addrPins;
    logic [dataWidth-1:0] dataPinsOut, dataPinsIn, readData;
    irqReport  irq;

    logic [31:0] lcgState = 32'd72284;
    int errors = 0;
    int checks = 0;
    int stepCount = 0;
    int cycleCount = 0;                 // Watchdog

    //------------------------------------------------------------
    // Model state
    //------------------------------------------------------------
    busReq curReq;                      // Cycle the model is running
    logic [dataWidth-1:0] curDin;       // D pins held during it
    int    curRepeats, curHold, startStep;
    logic  curBurst;
    tState entState[16];                // One entry per lastT cycle
    logic  entLow[16];
    logic  entWait[16];                 // WAIT level at the test state low half
    int    entCount, entIdx;
    logic  active, expBusack, nmiQ, nmiPend, readySeen;
    int    holdLeft;                    // BUSRQ cycles left after cycleDone

    busCycleTop dut_i (
        .lastT(lastT), .rstN(rstN), .req(req), .mwait(mwait), .busrq(busrq),
        .intr(intr), .nmi(nmi), .pins(pins), .busack(busack), .addrPins(addrPins),
        .addrOe(addrOe), .dataPinsOut(dataPinsOut), .dataOe(dataOe),
        .dataPinsIn(dataPinsIn), .readData(readData), .cycleDone(cycleDone),
        .ready(ready), .irq(irq)
    );

    always #10 lastT = ~lastT;

    always @(posedge lastT) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("Timeout after %0d cycles, the bus cycles stopped making progress", cycleCount);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] randWord();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {16'd0, lcgState[30:15]};    // Upper bits only as the low ones cycle fast
    endfunction

    task automatic compareHex(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%h, expected 0x%h, step %0d", name, got, exp, stepCount);
        end
    endtask

    // Expand a function and its WAIT repeats into per-cycle entries
    task automatic planCycle(input busFunc f, input int repeats);
        int i;
        int k;
        tState s;
        entCount = 0;
        for (i = 0; i < stateCount(f); i++) begin
            s = stateAt(f, i);
            for (k = 0; k <= ((s == waitState(f)) ? repeats : 0); k++) begin
                entState[entCount]     = s;
                entLow[entCount]       = 1'b0;
                entState[entCount + 1] = s;
                entLow[entCount + 1]   = 1'b1;
                entWait[entCount + 1]  = (k < repeats);
                entCount += 2;
            end
        end
    endtask

    //------------------------------------------------------------
    // One lastT cycle with drive after the edge and check at the fall
    //------------------------------------------------------------
    task automatic clockStep(input logic startNow);
        logic readyExp;
        logic doneExp;
        tState s;
        @(posedge lastT);
        #2;
        readyExp = !active && !expBusack;
        s        = active ? entState[entIdx] : tIdle;
        doneExp  = active && (entIdx == entCount - 1);
        if (startNow) begin
            req.func  = busFunc'(3'(randWord() % 6));
            req.addr  = 16'(randWord());
            req.wdata = 8'(randWord());
            req.start = 1'b1;
        end else begin
            req.start = !readyExp && (randWord() % 8) == 0;   // Must be dropped
        end
        if (active && entLow[entIdx] && s == waitState(curReq.func))
            mwait = entWait[entIdx];
        else
            mwait = (randWord() % 2) == 1;                      // Not sampled here
        if (doneExp)
            busrq = curBurst;
        else if (holdLeft > 0)
            busrq = 1'b1;
        else if (expBusack)
            busrq = 1'b0;                                       // Release the bus
        else
            busrq = (randWord() % 2) == 1;
        intr       = (randWord() % 2) == 1;
        nmi        = (randWord() % 12) == 0;
        dataPinsIn = active ? curDin : 8'(randWord());

        @(negedge lastT);
        stepCount++;
        compareHex("pins", 16'(pins), 16'(expPins(curReq.func, s, entLow[entIdx])));
        compareHex("cycleDone", 16'(cycleDone), 16'(doneExp));
        compareHex("ready", 16'(ready), 16'(readyExp));
        compareHex("busack", 16'(busack), 16'(expBusack));
        compareHex("addrOe", 16'(addrOe), 16'(!expBusack));
        compareHex("irq", 16'(irq), 16'(irqExpect(doneExp, nmiPend, intr)));
        compareHex("dataOe", 16'(dataOe), 16'(drivesData(curReq.func, s, entLow[entIdx])));
        if (dataOe)
            compareHex("dataPinsOut", 16'(dataPinsOut), 16'(curReq.wdata));
        if (active && entIdx > 0)                               // A latch loads at end of T1 high
            compareHex("addrPins", addrPins, curReq.addr);
        if (doneExp && readsBack(curReq.func))
            compareHex("readData", 16'(readData), 16'(curDin));
        if (cycleDone)
            compareHex("latency", 16'(stepCount - startStep),
                       16'(latencyOf(curReq.func, curRepeats)));

        // Advance the model to the next cycle
        nmiPend = nmiNext(nmi && !nmiQ, nmiPend, doneExp);
        nmiQ    = nmi;
        if (doneExp || expBusack)
            expBusack = busrq;
        if (holdLeft > 0)
            holdLeft--;
        else if (doneExp && curBurst)
            holdLeft = curHold;
        if (doneExp)
            active = 1'b0;
        else if (active)
            entIdx++;
        if (req.start && readyExp) begin
            curReq     = req;
            curDin     = 8'(randWord());
            curRepeats = int'(randWord() % 3);                  // WAIT repeats 0 to 2
            curBurst   = (randWord() % 4) == 0;
            curHold    = 1 + int'(randWord() % 4);
            planCycle(curReq.func, curRepeats);
            entIdx     = 0;
            active     = 1'b1;
            startStep  = stepCount;
        end
        readySeen = ready && !req.start;
    endtask

    //------------------------------------------------------------
    // Reset, requests and closing report
    //------------------------------------------------------------
    initial begin
        int r;
        rstN       = 1'b0;
        req        = '0;
        mwait      = 1'b0;
        busrq      = 1'b0;
        intr       = 1'b0;
        nmi        = 1'b0;
        dataPinsIn = '0;
        curReq     = '0;
        curDin     = '0;
        curRepeats = 0;
        curHold    = 0;
        curBurst   = 1'b0;
        startStep  = 0;
        entCount   = 0;
        entIdx     = 0;
        active     = 1'b0;
        expBusack  = 1'b0;
        nmiQ       = 1'b0;
        nmiPend    = 1'b0;
        readySeen  = 1'b0;
        holdLeft   = 0;
        repeat (5) @(posedge lastT);
        #2;
        checks++;
        if (addrOe !== 1'b0 || pins !== '0 || busack !== 1'b0) begin
            errors++;
            $display("Address pins, strobes or busack were active during reset");
        end
        rstN = 1'b1;
        for (r = 0; r < numReqs; r++) begin
            while (!readySeen)
                clockStep(1'b0);
            repeat (int'(randWord() % 3)) clockStep(1'b0);     // Idle gap while ready
            clockStep(1'b1);
        end
        while (active || expBusack)
            clockStep(1'b0);
        $display("%0d requests, %0d checks, %0d errors", numReqs, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- hw/busCycleTop.sv
// Z80 bus cycle unit

module busCycleTop (
    input  logic                            lastT,
    input  logic                            rstN,
    input  z80BusPkg::busReq                req,         // Cycle request from the core
    input  logic                            mwait,       // WAIT
    input  logic                            busrq,       // BUSRQ
    input  logic                            intr,        // INT
    input  logic                            nmi,         // NMI
    output z80PadPkg::pinStrobes            pins,
    output logic                            busack,
    output logic [z80BusPkg::addrWidth-1:0] addrPins,
    output logic                            addrOe,
    output logic [z80BusPkg::dataWidth-1:0] dataPinsOut,
    output logic                            dataOe,
    input  logic [z80BusPkg::dataWidth-1:0] dataPinsIn,
    output logic [z80BusPkg::dataWidth-1:0] readData,
    output logic                            cycleDone,
    output logic                            ready,
    output z80PadPkg::irqReport             irq
);

    import z80BusPkg::*;
    import z80PadPkg::*;

    busFunc curFunc;
    tState  curState;
    logic   halfLow;
    logic   holdClk;                    // WAIT stretch back to the sequencer
    padCtrl pads;

    //------------------------------------------------------------
    // Sequencer, pin control and pads
    //------------------------------------------------------------
    cycleSequencer seq_i (
        .lastT(lastT), .rstN(rstN), .req(req), .holdClk(holdClk), .busack(busack),
        .curFunc(curFunc), .curState(curState), .halfLow(halfLow),
        .cycleDone(cycleDone), .ready(ready)
    );

    pinControl pinCtl_i (
        .lastT(lastT), .rstN(rstN), .curFunc(curFunc), .curState(curState),
        .halfLow(halfLow), .cycleDone(cycleDone),
        .mwait(mwait), .busrq(busrq), .intr(intr), .nmi(nmi),
        .pins(pins), .pads(pads), .holdClk(holdClk), .busack(busack), .irq(irq)
    );

    // Request fields go straight to the latches, loaded in T1
    padLatches pads_i (
        .lastT(lastT), .rstN(rstN), .pads(pads),
        .addrIn(req.addr), .wdataIn(req.wdata), .dataPinsIn(dataPinsIn),
        .addrPins(addrPins), .addrOe(addrOe),
        .dataPinsOut(dataPinsOut), .dataOe(dataOe), .readData(readData)
    );

endmodule

//--- pinControl/padLatches.sv
// Address and data pad latches

module padLatches (
    input  logic                            lastT,
    input  logic                            rstN,
    input  z80PadPkg::padCtrl               pads,        // Enables from pin control
    input  logic [z80BusPkg::addrWidth-1:0] addrIn,      // Request address
    input  logic [z80BusPkg::dataWidth-1:0] wdataIn,     // Request write data
    input  logic [z80BusPkg::dataWidth-1:0] dataPinsIn,  // D pins as seen from outside
    output logic [z80BusPkg::addrWidth-1:0] addrPins,
    output logic                            addrOe,
    output logic [z80BusPkg::dataWidth-1:0] dataPinsOut,
    output logic                            dataOe,
    output logic [z80BusPkg::dataWidth-1:0] readData     // Data to the core
);

    import z80BusPkg::*;

    logic [addrWidth-1:0] addrLatch;    // Address pad latch
    logic [dataWidth-1:0] doutLatch;    // Data toward the pins
    logic [dataWidth-1:0] dinLatch;     // Data captured from the pins
    logic [dataWidth-1:0] readHold;     // Last value passed to the core

    //------------------------------------------------------------
    // Address side
    //------------------------------------------------------------
    // A pins come out of reset at zero
    always_ff @(posedge lastT) begin
        if (!rstN) begin
            addrLatch <= '0;
        end else if (pads.abPinWe) begin
            addrLatch <= addrIn;
        end
    end

    assign addrPins = addrLatch;
    assign addrOe   = pads.abPinOe;     // Low in reset and bus hold

    //------------------------------------------------------------
    // Data side
    //------------------------------------------------------------
    always_ff @(posedge lastT) begin
        if (pads.dbWe) begin
            doutLatch <= wdataIn;       // Loaded in T1 of a write
        end
        if (pads.dbPinRe) begin
            dinLatch <= dataPinsIn;     // Sampled pin value
        end
        if (pads.dbOe) begin
            readHold <= dinLatch;
        end
    end

    assign dataPinsOut = doutLatch;
    assign dataOe      = pads.dbPinOe;  // Only during write cycles

    // Latch value goes straight through while dbOe is up
    // So read data is already valid in the cycleDone cycle
    assign readData = pads.dbOe ? dinLatch : readHold;

endmodule

//--- pinControl/pinControl.sv
// Bus pin control

module pinControl (
    input  logic              lastT,
    input  logic              rstN,
    input  z80BusPkg::busFunc curFunc,
    input  z80BusPkg::tState  curState,
    input  logic              halfLow,    // Low half as the old ~clk
    input  logic              cycleDone,
    input  logic              mwait,      // WAIT, external device not ready
    input  logic              busrq,      // BUSRQ, outside master wants the bus
    input  logic              intr,       // INT level
    input  logic              nmi,        // NMI level
    output z80PadPkg::pinStrobes pins,
    output z80PadPkg::padCtrl    pads,
    output logic              holdClk,    // Repeat the current T-state
    output logic              busack,
    output z80PadPkg::irqReport  irq
);

    import z80BusPkg::*;
    import z80PadPkg::*;

    logic fFetch, fMRead, fMWrite, fIORead, fIOWrite, fIntr;
    logic isT1, isT2, isT3, isT4, isTw1, isTw2;
    logic hi, lo;                       // Half-phase terms
    logic testW;                        // WAIT test state of this function
    logic ctlOe;                        // Control pins released on bus hold
    logic outOfReset;                   // Set on the first cycle after reset
    logic busrqLatch;                   // BUSRQ sample, also the BUSACK level
    logic nmiQ;                         // NMI one cycle back
    logic nmiRise;
    logic nmiPending;
    pinStrobes strobes;                 // Decoded before the output enable

    assign fFetch   = (curFunc == fetch);
    assign fMRead   = (curFunc == memRead);
    assign fMWrite  = (curFunc == memWrite);
    assign fIORead  = (curFunc == ioRead);
    assign fIOWrite = (curFunc == ioWrite);
    assign fIntr    = (curFunc == intrAck);

    assign isT1  = (curState == t1);
    assign isT2  = (curState == t2);
    assign isT3  = (curState == t3);
    assign isT4  = (curState == t4);
    assign isTw1 = (curState == tw1);
    assign isTw2 = (curState == tw2);

    assign hi = !halfLow;
    assign lo = halfLow;

    //------------------------------------------------------------
    // Strobe equations with clk high as the high half
    //------------------------------------------------------------
    always_comb begin
        strobes.m1   = (fFetch & (isT1 | isT2)) |
                       (fIntr & (isT1 | isT2 | isTw1 | isTw2));
        strobes.mreq = (fFetch & (isT1 & lo | isT2 | isT3 & lo | isT4 & hi)) |
                       ((fMRead | fMWrite) & (isT1 & lo | isT2 | isT3 & hi)) |
                       (fIntr & (isTw1 & lo | isTw2 & hi));
        strobes.iorq = ((fIORead | fIOWrite) & (isT2 | isT3 | isT4 & hi)) |
                       (fIntr & (isTw1 & lo | isTw2));
        strobes.rd   = (fFetch & (isT1 & lo | isT2)) |
                       (fMRead & (isT1 & lo | isT2 | isT3 & hi)) |
                       (fIORead & (isT2 | isT3 | isT4 & hi));
        strobes.wr   = (fMWrite & (isT2 & lo | isT3 & hi)) |
                       (fIOWrite & (isT2 | isT3 | isT4 & hi));
        strobes.rfsh = (fFetch & (isT3 | isT4)) |
                       (fIntr & (isTw1 | isTw2));     // Refresh strobe only without address
    end

    assign pins = pads.busPinOe ? strobes : '0;

    //------------------------------------------------------------
    // Pad latch enables
    //------------------------------------------------------------
    assign ctlOe = outOfReset && !busrqLatch;   // Pins given up in reset and bus hold

    always_comb begin
        pads.abPinOe  = ctlOe;
        pads.busPinOe = ctlOe;
        pads.abPinWe  = isT1 & hi;              // Every function loads A in T1
        pads.dbPinOe  = (fMWrite & (isT1 & lo | isT2 | isT3)) |
                        (fIOWrite & (isT1 & lo | isT2 | isT3 | isT4));
        pads.dbPinRe  = (fFetch & isT2) |
                        (fMRead & isT3 & hi) |
                        (fIORead & isT4 & hi) |
                        (fIntr & isTw2 & hi);   // Vector read early as the cycle ends in this low half
        pads.dbWe     = (fMWrite | fIOWrite) & isT1 & hi;
        pads.dbOe     = (fFetch & isT3) |
                        (fMRead & isT3 & lo) |
                        (fIORead & isT4 & lo) |
                        (fIntr & isTw2 & lo);
    end

    // WAIT test point per function
    assign testW = ((fFetch | fMRead | fMWrite) & isT2) |
                   ((fIORead | fIOWrite) & isT3) |
                   (fIntr & isTw2);

    // WAIT sampled in the low half of the test state
    assign holdClk = testW & lo & mwait;

    //------------------------------------------------------------
    // BUSRQ, NMI and INTR
    //------------------------------------------------------------
    assign nmiRise = nmi && !nmiQ;

    always_ff @(posedge lastT) begin
        if (!rstN) begin
            outOfReset <= 1'b0;
            busrqLatch <= 1'b0;
            nmiQ       <= 1'b0;
            nmiPending <= 1'b0;
        end else begin
            outOfReset <= 1'b1;
            nmiQ       <= nmi;
            // Edge latched at any time and consumed at the end of a cycle
            nmiPending <= nmiRise || (nmiPending && !cycleDone);
            // Sampled at cycle end and then every cycle while the bus is held
            if (cycleDone || busrqLatch) begin
                busrqLatch <= busrq;
            end
        end
    end

    assign busack = busrqLatch;         // One cycle behind the BUSRQ sample

    // NMI has priority over INTR
    assign irq.nmiTaken = cycleDone && nmiPending;
    assign irq.intTaken = cycleDone && !nmiPending && intr;

endmodule

//--- hw/cycleSequencer.sv
// T-state sequencer

module cycleSequencer (
    input  logic             lastT,     // Fast clock, two per T-state
    input  logic             rstN,
    input  z80BusPkg::busReq req,       // Request from the core
    input  logic             holdClk,   // WAIT stretch from pin control
    input  logic             busack,    // Bus handed to an outside master
    output z80BusPkg::busFunc curFunc,
    output z80BusPkg::tState  curState,
    output logic             halfLow,   // Low half of the T-state, the old ~clk
    output logic             cycleDone, // Low half of the final T-state
    output logic             ready      // Core may start a cycle
);

    import z80BusPkg::*;

    //------------------------------------------------------------
    // Per-function T-state order
    //------------------------------------------------------------
    // Final T-state of each function
    function automatic tState finalState(input busFunc f);
        case (f)
            memRead, memWrite: finalState = t3;
            intrAck:           finalState = tw2;
            default:           finalState = t4;  // Fetch and both I/O cycles
        endcase
    endfunction

    // Successor of a T-state that is not the final one
    function automatic tState nextState(input busFunc f, input tState s);
        case (s)
            t1:      nextState = t2;
            t2:      nextState = (f == intrAck) ? tw1 : t3;
            tw1:     nextState = tw2;
            t3:      nextState = t4;
            default: nextState = tIdle;
        endcase
    endfunction

    logic isFinal;                      // Current T-state ends the cycle

    assign isFinal = (curState == finalState(curFunc));

    //------------------------------------------------------------
    // State and half-phase
    //------------------------------------------------------------
    always_ff @(posedge lastT) begin
        if (!rstN) begin
            curFunc  <= fetch;
            curState <= tIdle;
            halfLow  <= 1'b0;
        end else if (curState == tIdle) begin
            if (req.start && ready) begin   // Starts while not ready are dropped
                curFunc  <= req.func;
                curState <= t1;
                halfLow  <= 1'b0;
            end
        end else if (!halfLow) begin
            halfLow <= 1'b1;                // High half done
        end else begin
            halfLow <= 1'b0;
            // WAIT seen in the test state repeats the whole T-state
            if (!holdClk) begin
                curState <= isFinal ? tIdle : nextState(curFunc, curState);
            end
        end
    end

    // End of cycle, held off while a wait repeat is pending
    // Matters for the interrupt response where Tw2 is also the test state
    assign cycleDone = halfLow && isFinal && !holdClk;

    // Busy, or the bus belongs to someone else
    assign ready = (curState == tIdle) && !busack;

endmodule

//--- common/z80PadPkg.sv
// Z80 pin and pad control definitions

package z80PadPkg;

    // Control strobes, positive logic
    // Inversion to the real active-low pins happens outside
    typedef struct packed {
        logic m1;                       // Opcode fetch or interrupt response
        logic mreq;                     // Memory request
        logic iorq;                     // I/O request or interrupt acknowledge
        logic rd;                       // Read
        logic wr;                       // Write
        logic rfsh;                     // Refresh phase
    } pinStrobes;

    //------------------------------------------------------------
    // Enables for the address and data pad latches
    //------------------------------------------------------------
    typedef struct packed {
        logic abPinOe;                  // Drive the address pins
        logic busPinOe;                 // Drive MREQ, IORQ, RD, WR, RFSH
        logic abPinWe;                  // Load the address pad latch
        logic dbPinOe;                  // Drive the data pins from the out latch
        logic dbPinRe;                  // Capture the data pins into the in latch
        logic dbWe;                     // Load the out latch from write data
        logic dbOe;                     // Pass the in latch to read data
    } padCtrl;

    // Interrupts accepted at the end of a cycle
    typedef struct packed {
        logic nmiTaken;                 // NMI wins over INTR
        logic intTaken;
    } irqReport;

endpackage

//--- common/z80BusPkg.sv
// Z80 bus cycle definitions

package z80BusPkg;

    //------------------------------------------------------------
    // Bus widths, fixed by the architecture
    //------------------------------------------------------------
    localparam int addrWidth = 16;      // A15..A0
    localparam int dataWidth = 8;       // D7..D0

    //------------------------------------------------------------
    // Bus-cycle functions
    //------------------------------------------------------------
    typedef enum logic [2:0] {
        fetch    = 3'd0,                // Opcode fetch, the M1 cycle
        memRead  = 3'd1,                // Memory read
        memWrite = 3'd2,                // Memory write
        ioRead   = 3'd3,                // Port read
        ioWrite  = 3'd4,                // Port write
        intrAck  = 3'd5                 // Interrupt response
    } busFunc;

    // T-states of the current machine cycle
    typedef enum logic [2:0] {
        tIdle = 3'd0,                   // No cycle running
        t1    = 3'd1,
        t2    = 3'd2,
        t3    = 3'd3,
        t4    = 3'd4,
        tw1   = 3'd5,                   // Auto wait states of the interrupt response
        tw2   = 3'd6
    } tState;

    //------------------------------------------------------------
    // Request from the core
    //------------------------------------------------------------
    // Address and write data stay valid through T1 of the cycle
    typedef struct packed {
        logic                 start;    // One-cycle start strobe
        busFunc               func;     // Which bus cycle to run
        logic [addrWidth-1:0] addr;     // Address driven on A
        logic [dataWidth-1:0] wdata;    // Data for write cycles
    } busReq;

endpackage
